//--- verilog/frontend_pkg.sv
// shared widths, sizes and payload types of the front end
// instruction, buffer entry and register index types

package frontend_pkg;

    ////////////////////////////////
    // sizes
    ////////////////////////////////

    localparam int FETCH_WIDTH    = 4;   // lanes offered per cycle
    localparam int DISPATCH_WIDTH = 2;   // renames per cycle
    localparam int IB_DEPTH       = 8;
    localparam int ARCH_REG_SZ    = 32;
    localparam int PHYS_REG_SZ    = 64;
    localparam int FREE_SZ        = PHYS_REG_SZ - ARCH_REG_SZ;
    localparam int INST_BYTES     = 4;   // pc step per instruction

    ////////////////////////////////
    // index and count types
    ////////////////////////////////

    typedef logic [31:0]                           addr_t;
    typedef logic [$clog2(ARCH_REG_SZ)-1:0]        arch_reg_t;
    typedef logic [$clog2(PHYS_REG_SZ)-1:0]        phys_reg_t;

    typedef logic [$clog2(FETCH_WIDTH+1)-1:0]      fetch_cnt_t;
    typedef logic [$clog2(IB_DEPTH+1)-1:0]         ib_cnt_t;
    typedef logic [$clog2(DISPATCH_WIDTH+1)-1:0]   dis_cnt_t;
    typedef logic [$clog2(FREE_SZ+1)-1:0]          free_cnt_t;

    ////////////////////////////////
    // payloads
    ////////////////////////////////

    typedef struct packed {
        arch_reg_t dest;
        arch_reg_t src1;
        arch_reg_t src2;
    } inst_t;

    typedef struct packed {
        inst_t inst;
        addr_t addr;   // pc tag from fetch
    } ib_entry_t;

endpackage

//--- verilog/fetch_unit.sv
// fetch unit
// clamps the offered group to buffer space, tags lanes with their pc
// and holds the next fetch address

`timescale 1ns/10ps

module fetch_unit import frontend_pkg::*; (
    input  logic                          clock,
    input  logic                          reset,
    input  inst_t      [FETCH_WIDTH-1:0]  in_insts,
    input  fetch_cnt_t                    num_input,
    input  ib_cnt_t                       ib_open,
    input  logic                          redirect,
    input  addr_t                         redirect_pc,
    output ib_entry_t  [FETCH_WIDTH-1:0]  wr_entries,
    output fetch_cnt_t                    wr_count,
    output addr_t                         npc
);

    ib_cnt_t accept;   // min of offered, free slots and lanes

    always_comb begin
        accept = ib_open;
        if (ib_cnt_t'(num_input) < accept) accept = ib_cnt_t'(num_input);
        if (ib_cnt_t'(FETCH_WIDTH) < accept) accept = ib_cnt_t'(FETCH_WIDTH);
        wr_count = redirect ? '0 : fetch_cnt_t'(accept);   // nothing taken on redirect
    end

    // lane k sits k words past npc
    always_comb begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            wr_entries[k].inst = in_insts[k];
            wr_entries[k].addr = npc + addr_t'(k * INST_BYTES);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            npc <= '0;
        end else if (redirect) begin
            npc <= redirect_pc;
        end else begin
            npc <= npc + addr_t'(wr_count) * addr_t'(INST_BYTES);
        end
    end

endmodule

//--- verilog/inst_buffer.sv
// instruction buffer
// circular queue, up to FETCH_WIDTH writes and DISPATCH_WIDTH reads a cycle,
// flush empties it after the cycle's pops

`timescale 1ns/10ps

module inst_buffer import frontend_pkg::*; (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             flush,
    input  ib_entry_t  [FETCH_WIDTH-1:0]     wr_entries,
    input  fetch_cnt_t                       wr_count,
    input  dis_cnt_t                         rd_count,
    output ib_entry_t  [DISPATCH_WIDTH-1:0]  rd_entries,
    output ib_cnt_t                          count,
    output ib_cnt_t                          open
);

    localparam int PTR_W = $clog2(IB_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;

    ib_entry_t mem [IB_DEPTH];
    ptr_t      head;   // oldest entry
    ptr_t      tail;   // next free slot

    ////////////////////////////////
    // read side
    ////////////////////////////////

    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            rd_entries[i] = mem[head + ptr_t'(i)];   // pointer wraps by width
        end
    end

    assign open = ib_cnt_t'(IB_DEPTH) - count;

    ////////////////////////////////
    // storage
    ////////////////////////////////

    // fetch never offers more than open, so no overwrite of live entries
    always_ff @(posedge clock) begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            if (!flush && k < wr_count) begin
                mem[tail + ptr_t'(k)] <= wr_entries[k];
            end
        end
    end

    ////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // pop, then drop whatever is left
            head  <= tail;
            count <= '0;
        end else begin
            head  <= head + ptr_t'(rd_count);
            tail  <= tail + ptr_t'(wr_count);
            count <= count + ib_cnt_t'(wr_count) - ib_cnt_t'(rd_count);
        end
    end

endmodule

//--- verilog/free_list.sv
// free list of physical registers
// circular queue preloaded at reset with the registers not in the map

`timescale 1ns/10ps

module free_list import frontend_pkg::*; (
    input  logic                              clock,
    input  logic                              reset,
    input  dis_cnt_t                          pop_count,
    input  logic                              push_valid,
    input  phys_reg_t                         push_reg,
    output phys_reg_t  [DISPATCH_WIDTH-1:0]   head_regs,
    output free_cnt_t                         count
);

    localparam int PTR_W = $clog2(FREE_SZ);

    typedef logic [PTR_W-1:0] ptr_t;

    phys_reg_t mem [FREE_SZ];
    ptr_t      head;
    ptr_t      tail;

    // next regs to hand out, only the first pop_count get used
    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            head_regs[i] = mem[head + ptr_t'(i)];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < FREE_SZ; i++) begin
                mem[i] <= phys_reg_t'(ARCH_REG_SZ + i);   // regs above the identity map
            end
        end else if (push_valid) begin
            mem[tail] <= push_reg;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;   // full queue, tail wraps onto head
            count <= free_cnt_t'(FREE_SZ);
        end else begin
            head  <= head + ptr_t'(pop_count);
            tail  <= tail + ptr_t'(push_valid);
            count <= count - free_cnt_t'(pop_count) + free_cnt_t'(push_valid);
        end
    end

endmodule

//--- verilog/map_table.sv
// architectural to physical register map
// lookups with bypass from earlier slots of the same group

`timescale 1ns/10ps

module map_table import frontend_pkg::*; (
    input  logic                              clock,
    input  logic                              reset,
    input  arch_reg_t  [DISPATCH_WIDTH-1:0]   dest,
    input  arch_reg_t  [DISPATCH_WIDTH-1:0]   src1,
    input  arch_reg_t  [DISPATCH_WIDTH-1:0]   src2,
    input  phys_reg_t  [DISPATCH_WIDTH-1:0]   new_preg,
    input  dis_cnt_t                          write_count,
    output phys_reg_t  [DISPATCH_WIDTH-1:0]   src1_preg,
    output phys_reg_t  [DISPATCH_WIDTH-1:0]   src2_preg,
    output phys_reg_t  [DISPATCH_WIDTH-1:0]   old_preg
);

    phys_reg_t table_q [ARCH_REG_SZ];

    // earlier slot in the group overrides the table, the latest one wins
    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            src1_preg[i] = table_q[src1[i]];
            src2_preg[i] = table_q[src2[i]];
            old_preg[i]  = table_q[dest[i]];
            for (int j = 0; j < i; j++) begin
                if (src1[i] == dest[j]) src1_preg[i] = new_preg[j];
                if (src2[i] == dest[j]) src2_preg[i] = new_preg[j];
                if (dest[i] == dest[j]) old_preg[i]  = new_preg[j];   // waw in group
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < ARCH_REG_SZ; r++) begin
                table_q[r] <= phys_reg_t'(r);   // identity
            end
        end else begin
            // slot order, so a later slot overwrites the same dest
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                if (i < write_count) table_q[dest[i]] <= new_preg[i];
            end
        end
    end

endmodule

//--- verilog/rename_dispatch.sv
// rename and dispatch stage
// picks the dispatch count, renames through map table and free list

`timescale 1ns/10ps

module rename_dispatch import frontend_pkg::*; (
    input  logic                              clock,
    input  logic                              reset,
    input  ib_entry_t  [DISPATCH_WIDTH-1:0]   rd_entries,
    input  ib_cnt_t                           ib_count,
    input  logic                              dispatch_stall,
    input  logic                              retire_valid,
    input  phys_reg_t                         retire_preg,
    output dis_cnt_t                          rd_count,
    output addr_t      [DISPATCH_WIDTH-1:0]   dis_addr,
    output arch_reg_t  [DISPATCH_WIDTH-1:0]   dis_dest,
    output phys_reg_t  [DISPATCH_WIDTH-1:0]   dis_dest_preg,
    output phys_reg_t  [DISPATCH_WIDTH-1:0]   dis_src1_preg,
    output phys_reg_t  [DISPATCH_WIDTH-1:0]   dis_src2_preg,
    output phys_reg_t  [DISPATCH_WIDTH-1:0]   dis_old_preg
);

    arch_reg_t [DISPATCH_WIDTH-1:0] dest, src1, src2;
    phys_reg_t [DISPATCH_WIDTH-1:0] free_regs, src1_preg, src2_preg, old_preg;
    free_cnt_t                      free_count;
    free_cnt_t                      limit;

    ////////////////////////////////
    // dispatch count
    ////////////////////////////////

    always_comb begin
        limit = free_cnt_t'(DISPATCH_WIDTH);
        if (free_cnt_t'(ib_count) < limit) limit = free_cnt_t'(ib_count);
        if (free_count < limit) limit = free_count;   // out of registers
        rd_count = dispatch_stall ? '0 : dis_cnt_t'(limit);
    end

    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            dest[i] = rd_entries[i].inst.dest;
            src1[i] = rd_entries[i].inst.src1;
            src2[i] = rd_entries[i].inst.src2;
        end
    end

    free_list i_free_list (
        .clock(clock),
        .reset(reset),
        .pop_count(rd_count),
        .push_valid(retire_valid),
        .push_reg(retire_preg),
        .head_regs(free_regs),
        .count(free_count)
    );

    map_table i_map_table (
        .clock(clock),
        .reset(reset),
        .dest(dest),
        .src1(src1),
        .src2(src2),
        .new_preg(free_regs),
        .write_count(rd_count),
        .src1_preg(src1_preg),
        .src2_preg(src2_preg),
        .old_preg(old_preg)
    );

    ////////////////////////////////
    // renamed slots
    ////////////////////////////////

    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            if (i < rd_count) begin
                dis_addr[i]      = rd_entries[i].addr;
                dis_dest[i]      = dest[i];
                dis_dest_preg[i] = free_regs[i];
                dis_src1_preg[i] = src1_preg[i];
                dis_src2_preg[i] = src2_preg[i];
                dis_old_preg[i]  = old_preg[i];
            end else begin   // idle slot reads zero
                dis_addr[i]      = '0;
                dis_dest[i]      = '0;
                dis_dest_preg[i] = '0;
                dis_src1_preg[i] = '0;
                dis_src2_preg[i] = '0;
                dis_old_preg[i]  = '0;
            end
        end
    end

endmodule

//--- verilog/frontend_top.sv
// front end top level
// fetch unit, instruction buffer and rename/dispatch connected in order

`timescale 1ns/10ps

module frontend_top import frontend_pkg::*; (
    input  logic                              clock,
    input  logic                              reset,
    input  inst_t      [FETCH_WIDTH-1:0]      in_insts,
    input  fetch_cnt_t                        num_input,
    input  logic                              redirect,
    input  addr_t                             redirect_pc,
    input  logic                              dispatch_stall,
    input  logic                              retire_valid,
    input  phys_reg_t                         retire_preg,
    output addr_t                             npc,
    output ib_cnt_t                           ib_open,
    output dis_cnt_t                          num_dispatched,
    output addr_t      [DISPATCH_WIDTH-1:0]   dis_addr,
    output arch_reg_t  [DISPATCH_WIDTH-1:0]   dis_dest,
    output phys_reg_t  [DISPATCH_WIDTH-1:0]   dis_dest_preg,
    output phys_reg_t  [DISPATCH_WIDTH-1:0]   dis_src1_preg,
    output phys_reg_t  [DISPATCH_WIDTH-1:0]   dis_src2_preg,
    output phys_reg_t  [DISPATCH_WIDTH-1:0]   dis_old_preg
);

    ib_entry_t [FETCH_WIDTH-1:0]    wr_entries;
    fetch_cnt_t                     wr_count;
    ib_entry_t [DISPATCH_WIDTH-1:0] rd_entries;
    ib_cnt_t                        ib_count;
    dis_cnt_t                       rd_count;

    assign num_dispatched = rd_count;

    fetch_unit i_fetch_unit (
        .clock(clock),
        .reset(reset),
        .in_insts(in_insts),
        .num_input(num_input),
        .ib_open(ib_open),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .wr_entries(wr_entries),
        .wr_count(wr_count),
        .npc(npc)
    );

    inst_buffer i_inst_buffer (
        .clock(clock),
        .reset(reset),
        .flush(redirect),   // wrong-path entries dropped
        .wr_entries(wr_entries),
        .wr_count(wr_count),
        .rd_count(rd_count),
        .rd_entries(rd_entries),
        .count(ib_count),
        .open(ib_open)
    );

    rename_dispatch i_rename_dispatch (
        .clock(clock),
        .reset(reset),
        .rd_entries(rd_entries),
        .ib_count(ib_count),
        .dispatch_stall(dispatch_stall),
        .retire_valid(retire_valid),
        .retire_preg(retire_preg),
        .rd_count(rd_count),
        .dis_addr(dis_addr),
        .dis_dest(dis_dest),
        .dis_dest_preg(dis_dest_preg),
        .dis_src1_preg(dis_src1_preg),
        .dis_src2_preg(dis_src2_preg),
        .dis_old_preg(dis_old_preg)
    );

endmodule

//--- verif/frontend_model.svh
// reference model of the front end
// buffer contents, fetch address, map table and free queue, stepped per edge

`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

addr_t     exp_npc;
ib_entry_t ib_q [$];              // oldest entry at index 0
phys_reg_t map_q [ARCH_REG_SZ];
phys_reg_t free_q [$];            // next destination at index 0
phys_reg_t ret_q [$];             // old regs waiting for retirement

function automatic void reset_model();
    exp_npc = '0;
    ib_q.delete();
    free_q.delete();
    ret_q.delete();
    for (int r = 0; r < ARCH_REG_SZ; r++) map_q[r] = phys_reg_t'(r);
    for (int i = 0; i < FREE_SZ; i++) free_q.push_back(phys_reg_t'(ARCH_REG_SZ + i));
endfunction

// mapping seen by a slot, including renames of earlier slots in the group
function automatic phys_reg_t lookup_preg(input arch_reg_t r, input int slot);
    phys_reg_t p;
    p = map_q[r];
    for (int j = 0; j < slot; j++) begin
        if (ib_q[j].inst.dest == r) p = free_q[j];
    end
    return p;
endfunction

function automatic int expected_dispatch();
    int n;
    if (dispatch_stall) return 0;
    n = DISPATCH_WIDTH;
    if (ib_q.size() < n) n = ib_q.size();
    if (free_q.size() < n) n = free_q.size();   // out of free regs
    return n;
endfunction

// one rising edge: dispatch, retirement, then fetch or redirect
function automatic void advance_model(input int n);
    int        open;
    int        accept;
    ib_entry_t e;
    phys_reg_t old_regs [DISPATCH_WIDTH];
    open = IB_DEPTH - ib_q.size();   // fetch sees pre-edge space
    for (int i = 0; i < n; i++) old_regs[i] = lookup_preg(ib_q[i].inst.dest, i);
    for (int i = 0; i < n; i++) begin
        map_q[ib_q[i].inst.dest] = free_q[i];   // slot order, last write wins
        ret_q.push_back(old_regs[i]);
    end
    for (int i = 0; i < n; i++) begin
        ib_q.delete(0);
        free_q.delete(0);
    end
    if (retire_valid) begin
        free_q.push_back(retire_preg);
        ret_q.delete(0);
    end
    if (redirect) begin
        ib_q.delete();
        exp_npc = redirect_pc;
    end else begin
        accept = num_input;
        if (open < accept) accept = open;
        if (FETCH_WIDTH < accept) accept = FETCH_WIDTH;
        for (int k = 0; k < accept; k++) begin
            e.inst = in_insts[k];
            e.addr = exp_npc + addr_t'(k * INST_BYTES);
            ib_q.push_back(e);
        end
        exp_npc = exp_npc + addr_t'(accept * INST_BYTES);
    end
endfunction

`endif

//--- verif/frontend_tb.sv
// testbench for the front end
// lfsr stimulus, per-cycle comparison against the reference model, drain at the end

`timescale 1ns/10ps

module frontend_tb import frontend_pkg::*; ();

    localparam logic [31:0] SEED          = 32'hee75_b2aa;
    localparam int          CYCLES        = 2000;
    localparam int          DRAIN_TIMEOUT = 200;

    logic                              clock;
    logic                              reset;
    inst_t      [FETCH_WIDTH-1:0]      in_insts;
    fetch_cnt_t                        num_input;
    logic                              redirect;
    addr_t                             redirect_pc;
    logic                              dispatch_stall;
    logic                              retire_valid;
    phys_reg_t                         retire_preg;
    addr_t                             npc;
    ib_cnt_t                           ib_open;
    dis_cnt_t                          num_dispatched;
    addr_t      [DISPATCH_WIDTH-1:0]   dis_addr;
    arch_reg_t  [DISPATCH_WIDTH-1:0]   dis_dest;
    phys_reg_t  [DISPATCH_WIDTH-1:0]   dis_dest_preg;
    phys_reg_t  [DISPATCH_WIDTH-1:0]   dis_src1_preg;
    phys_reg_t  [DISPATCH_WIDTH-1:0]   dis_src2_preg;
    phys_reg_t  [DISPATCH_WIDTH-1:0]   dis_old_preg;

    logic [31:0] lfsr;

    `include "frontend_model.svh"

    frontend_top i_dut (
        .clock(clock),
        .reset(reset),
        .in_insts(in_insts),
        .num_input(num_input),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .dispatch_stall(dispatch_stall),
        .retire_valid(retire_valid),
        .retire_preg(retire_preg),
        .npc(npc),
        .ib_open(ib_open),
        .num_dispatched(num_dispatched),
        .dis_addr(dis_addr),
        .dis_dest(dis_dest),
        .dis_dest_preg(dis_dest_preg),
        .dis_src1_preg(dis_src1_preg),
        .dis_src2_preg(dis_src2_preg),
        .dis_old_preg(dis_old_preg)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    ////////////////////////////////
    // helpers
    ////////////////////////////////

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic compare(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("FAILED %s: got 0x%h expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic drive_inputs(input bit fetch_on);
        logic [31:0] stall_roll;
        logic [31:0] redirect_roll;
        logic [31:0] retire_roll;
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            in_insts[k].dest = arch_reg_t'(random_bits(5));
            in_insts[k].src1 = arch_reg_t'(random_bits(5));
            in_insts[k].src2 = arch_reg_t'(random_bits(5));
        end
        num_input     = fetch_on ? fetch_cnt_t'(random_bits(3) % 5) : '0;
        stall_roll    = random_bits(2);
        redirect_roll = random_bits(5);
        redirect_pc   = addr_t'(random_bits(30)) << 2;   // word aligned
        retire_roll   = random_bits(1);
        dispatch_stall = fetch_on && stall_roll == 0;     // about 1 in 4
        redirect       = fetch_on && redirect_roll == 0;  // about 1 in 32
        retire_valid   = ret_q.size() != 0 && retire_roll[0];
        retire_preg    = ret_q.size() != 0 ? ret_q[0] : '0;
    endtask

    ////////////////////////////////
    // checking
    ////////////////////////////////

    task automatic check_outputs();
        int n;
        n = expected_dispatch();
        compare("npc", npc, exp_npc);
        compare("ib_open", ib_open, IB_DEPTH - ib_q.size());
        compare("num_dispatched", num_dispatched, n);
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            if (i < n) begin
                compare($sformatf("dis_addr[%0d]", i), dis_addr[i], ib_q[i].addr);
                compare($sformatf("dis_dest[%0d]", i), dis_dest[i], ib_q[i].inst.dest);
                compare($sformatf("dis_dest_preg[%0d]", i), dis_dest_preg[i], free_q[i]);
                compare($sformatf("dis_src1_preg[%0d]", i), dis_src1_preg[i],
                        lookup_preg(ib_q[i].inst.src1, i));
                compare($sformatf("dis_src2_preg[%0d]", i), dis_src2_preg[i],
                        lookup_preg(ib_q[i].inst.src2, i));
                compare($sformatf("dis_old_preg[%0d]", i), dis_old_preg[i],
                        lookup_preg(ib_q[i].inst.dest, i));
            end else begin   // idle slot reads zero
                compare($sformatf("dis_*[%0d] idle", i),
                        {dis_addr[i], dis_dest[i], dis_dest_preg[i], dis_src1_preg[i],
                         dis_src2_preg[i], dis_old_preg[i]}, '0);
            end
        end
    endtask

    // drive at the falling edge, check and step the model at the rising edge
    task automatic run_cycle(input bit fetch_on);
        drive_inputs(fetch_on);
        @(posedge clock);
        check_outputs();
        advance_model(int'(num_dispatched));
        @(negedge clock);
    endtask

    initial begin
        int waited;
        lfsr           = SEED;
        reset          = 1'b1;
        in_insts       = '0;
        num_input      = '0;
        redirect       = 1'b0;
        redirect_pc    = '0;
        dispatch_stall = 1'b0;
        retire_valid   = 1'b0;
        retire_preg    = '0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        reset_model();
        check_outputs();   // state right after reset

        for (int c = 0; c < CYCLES; c++) begin
            run_cycle(1'b1);
        end

        // stop fetching and let the buffer empty
        waited = 0;
        while (ib_q.size() != 0) begin
            if (waited == DRAIN_TIMEOUT) begin
                fail_run("instruction buffer did not drain after fetch stopped");
            end else begin
                run_cycle(1'b0);
                waited++;
            end
        end
        compare("ib_open", ib_open, IB_DEPTH);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- all.f
+incdir+verif
verilog/frontend_pkg.sv
verilog/fetch_unit.sv
verilog/inst_buffer.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/rename_dispatch.sv
verilog/frontend_top.sv
verif/frontend_tb.sv

//--- run.sh
#!/bin/sh
# build and run the front end testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module frontend_tb -f all.f -o frontend_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/frontend_sim
if [ $? -ne 0 ]; then
    echo "simulation returned a failing status"
    exit 1
fi
exit 0
